// ==== rtl/display_timing_pkg.sv ====
`default_nettype none

package display_timing_pkg;

  // raster geometry, all counts in pixels or lines
  typedef struct packed {
    logic [9:0] h_active;
    logic [9:0] h_front;
    logic [9:0] h_sync;
    logic [9:0] h_back;
    logic [9:0] v_active;
    logic [9:0] v_front;
    logic [9:0] v_sync;
    logic [9:0] v_back;
  } scan_timing_t;

  // standard 640x480 at a 25 MHz pixel clock
  localparam scan_timing_t default_timing = '{
    h_active: 10'd640,
    h_front:  10'd16,
    h_sync:   10'd96,
    h_back:   10'd48,
    v_active: 10'd480,
    v_front:  10'd10,
    v_sync:   10'd2,
    v_back:   10'd33
  };

  // raster may only run once the pixel FIFO holds enough to start a frame
  typedef enum logic {
    wait_fill = 1'b0,
    scan      = 1'b1
  } scan_state_t;

  // x is horizontal, y is vertical
  typedef struct packed {
    logic [9:0] x;
    logic [9:0] y;
  } raster_pos_t;

endpackage

`default_nettype wire

// ==== rtl/display_top.sv ====
`default_nettype none

module display_top #(
  parameter display_timing_pkg::scan_timing_t timing = display_timing_pkg::default_timing,
  parameter int fifo_depth = 16,
  parameter int prefill    = 4
) (
  input  logic                    clk,
  input  logic                    reset,
  input  pixel_pkg::color_code_t  color_code,
  input  logic                    write_en,
  output logic                    fifo_full,
  output pixel_pkg::display_out_t display_out
);

  import pixel_pkg::*;

  localparam int level_w = $clog2(fifo_depth) + 1;

  // fifo side
  color_code_t        fifo_code;
  logic               fifo_empty;
  logic [level_w-1:0] fifo_level;
  logic               read_en;

  // raster control
  logic        run;
  logic        stall;
  logic        active;
  logic        frame_end;
  logic        pixel_valid;
  display_out_t pos_sync;

  pixel_fifo #(
    .payload_t (color_code_t),
    .depth     (fifo_depth)
  ) pixel_fifo_i (
    .clk        (clk),
    .reset      (reset),
    .write_en   (write_en),
    .write_data (color_code),
    .read_en    (read_en),
    .read_data  (fifo_code),
    .empty      (fifo_empty),
    .full       (fifo_full),
    .level      (fifo_level)
  );

  scan_fsm #(
    .fifo_depth (fifo_depth),
    .prefill    (prefill)
  ) scan_fsm_i (
    .clk         (clk),
    .reset       (reset),
    .fifo_empty  (fifo_empty),
    .fifo_level  (fifo_level),
    .active      (active),
    .frame_end   (frame_end),
    .run         (run),
    .stall       (stall),
    .read_en     (read_en),
    .pixel_valid (pixel_valid)
  );

  scan_counter #(
    .timing (timing)
  ) scan_counter_i (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .stall     (stall),
    .active    (active),
    .frame_end (frame_end),
    .pos       (),
    .sync_out  (pos_sync)
  );

  pixel_output_stage pixel_output_stage_i (
    .clk         (clk),
    .reset       (reset),
    .code        (fifo_code),
    .pixel_valid (pixel_valid),
    .sync_in     (pos_sync),
    .display_out (display_out)
  );

endmodule

`default_nettype wire

// ==== rtl/pixel_fifo.sv ====
`default_nettype none

module pixel_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 16
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   write_en,
  input  payload_t               write_data,
  input  logic                   read_en,
  output payload_t               read_data,
  output logic                   empty,
  output logic                   full,
  output logic [$clog2(depth):0] level
);

  localparam int addr_w = $clog2(depth);
  localparam logic [addr_w:0] depth_count = (addr_w + 1)'(depth);

  payload_t mem [depth];

  logic [addr_w-1:0] write_ptr;
  logic [addr_w-1:0] read_ptr;
  logic [addr_w:0]   count;
  logic              do_write;
  logic              do_read;

  // writes while full are dropped
  assign do_write = write_en && !full;
  assign do_read  = read_en && !empty;

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[write_ptr] <= write_data;
    end
  end

  // depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk) begin
    if (reset) begin
      write_ptr <= '0;
      read_ptr  <= '0;
      count     <= '0;
    end else begin
      if (do_write) begin
        write_ptr <= write_ptr + 1'b1;
      end
      if (do_read) begin
        read_ptr <= read_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head shown before the read, first word fall through
  assign read_data = mem[read_ptr];
  assign empty     = (count == '0);
  assign full      = (count == depth_count);
  assign level     = count;

  // reader side must check empty itself
  assert property (@(posedge clk) disable iff (reset) read_en |-> !empty)
    else $error("pixel fifo read while empty");

  assert property (@(posedge clk) disable iff (reset) count <= depth_count)
    else $error("pixel fifo level above depth");

endmodule

`default_nettype wire

// ==== rtl/pixel_output_stage.sv ====
`default_nettype none

module pixel_output_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  pixel_pkg::color_code_t  code,
  input  logic                    pixel_valid,
  input  pixel_pkg::display_out_t sync_in,
  output pixel_pkg::display_out_t display_out
);

  import pixel_pkg::*;

  display_out_t out_next;

  // stalled or blanked pixels go out black
  always_comb begin
    out_next       = sync_in;
    out_next.blank = sync_in.blank || !pixel_valid;
    out_next.rgb   = pixel_valid ? palette_lookup(code) : '0;
  end

  // aligns color with the sync of the same position
  always_ff @(posedge clk) begin
    if (reset) begin
      display_out.hsync <= 1'b1;
      display_out.vsync <= 1'b1;
      display_out.blank <= 1'b1;
      display_out.rgb   <= '0;
    end else begin
      display_out <= out_next;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pixel_pkg.sv ====
`default_nettype none

package pixel_pkg;

  // code written by the rasterizer side
  typedef logic [2:0] color_code_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // syncs are active low, blank is active high
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic blank;
    rgb_t rgb;
  } display_out_t;

  // one bit per channel, each channel fully on or off
  function automatic rgb_t palette_lookup(input color_code_t code);
    rgb_t color;
    color.r = code[2] ? 8'hff : 8'h00;
    color.g = code[1] ? 8'hff : 8'h00;
    color.b = code[0] ? 8'hff : 8'h00;
    return color;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/scan_counter.sv ====
`default_nettype none

module scan_counter #(
  parameter display_timing_pkg::scan_timing_t timing = display_timing_pkg::default_timing
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           run,
  input  logic                           stall,
  output logic                           active,
  output logic                           frame_end,
  output display_timing_pkg::raster_pos_t pos,
  output pixel_pkg::display_out_t        sync_out
);

  // last position of a line and of a frame
  localparam logic [9:0] h_last =
    10'(timing.h_active + timing.h_front + timing.h_sync + timing.h_back - 10'd1);
  localparam logic [9:0] v_last =
    10'(timing.v_active + timing.v_front + timing.v_sync + timing.v_back - 10'd1);

  // sync windows follow the front porch
  localparam logic [9:0] hs_start = 10'(timing.h_active + timing.h_front);
  localparam logic [9:0] hs_stop  = 10'(hs_start + timing.h_sync);
  localparam logic [9:0] vs_start = 10'(timing.v_active + timing.v_front);
  localparam logic [9:0] vs_stop  = 10'(vs_start + timing.v_sync);

  always_ff @(posedge clk) begin
    if (reset) begin
      pos <= '0;
    end else if (!run) begin
      pos <= '0;
    end else if (!stall) begin
      if (pos.x == h_last) begin
        pos.x <= '0;
        pos.y <= (pos.y == v_last) ? 10'd0 : pos.y + 10'd1;
      end else begin
        pos.x <= pos.x + 10'd1;
      end
    end
  end

  assign active    = (pos.x < timing.h_active) && (pos.y < timing.v_active);
  assign frame_end = (pos.x == h_last) && (pos.y == v_last);

  // sync decode, low inside the window
  assign sync_out.hsync = !((pos.x >= hs_start) && (pos.x < hs_stop));
  assign sync_out.vsync = !((pos.y >= vs_start) && (pos.y < vs_stop));
  assign sync_out.blank = !active;
  assign sync_out.rgb   = '0;

  // FSM may only hold the raster while a visible pixel is waiting
  assert property (@(posedge clk) disable iff (reset) stall |-> active)
    else $error("raster stalled outside the active area");

endmodule

`default_nettype wire

// ==== rtl/scan_fsm.sv ====
`default_nettype none

module scan_fsm #(
  parameter int fifo_depth = 16,
  parameter int prefill    = 4
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        fifo_empty,
  input  logic [$clog2(fifo_depth):0] fifo_level,
  input  logic                        active,
  input  logic                        frame_end,
  output logic                        run,
  output logic                        stall,
  output logic                        read_en,
  output logic                        pixel_valid
);

  import display_timing_pkg::*;

  localparam int level_w = $clog2(fifo_depth) + 1;
  localparam logic [level_w-1:0] prefill_level = level_w'(prefill);

  scan_state_t state;
  scan_state_t state_next;
  logic        filled;

  assign filled = (fifo_level >= prefill_level);

  // leaving scan only at frame end keeps each frame whole
  always_comb begin
    state_next = state;
    case (state)
      wait_fill: if (filled) state_next = scan;
      scan:      if (frame_end && !filled) state_next = wait_fill;
      default:   state_next = wait_fill;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= wait_fill;
    end else begin
      state <= state_next;
    end
  end

  assign run = (state == scan);

  // one read per visible pixel, hold the raster on underrun
  assign read_en     = run && active && !fifo_empty;
  assign stall       = run && active && fifo_empty;
  assign pixel_valid = read_en;

  assert property (@(posedge clk) disable iff (reset) !(read_en && stall))
    else $error("read and stall in the same cycle");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --top-module display_tb -f verilog.f \
  && ./obj_dir/Vdisplay_tb | tee /dev/stderr | grep -q "TB PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== verification/display_tb.sv ====
`default_nettype none

module display_tb;

  import display_timing_pkg::*;
  import pixel_pkg::*;

  // small raster of 14 cycles per line and 6 lines per frame
  localparam scan_timing_t tb_timing = '{
    h_active: 10'd8,
    h_front:  10'd2,
    h_sync:   10'd2,
    h_back:   10'd2,
    v_active: 10'd3,
    v_front:  10'd1,
    v_sync:   10'd1,
    v_back:   10'd1
  };
  localparam int fifo_depth   = 8;
  localparam int prefill      = 4;
  localparam int line_len     = 14;
  localparam int line_pixels  = 8;
  localparam int frame_pixels = 24;
  localparam int hsync_width  = 2;
  localparam int table_len    = 16;
  localparam int random_count = 32;
  localparam int total_writes = table_len + random_count;
  localparam int wait_limit   = 200;
  localparam int run_limit    = 5000;

  // idle cycles come before the write of each row
  typedef struct packed {
    color_code_t code;
    logic [7:0]  idle;
  } stim_row_t;

  logic         clk;
  logic         reset;
  color_code_t  color_code;
  logic         write_en;
  logic         fifo_full;
  display_out_t display_out;

  stim_row_t   stim_table [table_len];
  color_code_t expected_codes [$];

  int   accepted_count;
  int   line_count;
  int   frame_count;
  int   frames_seen;
  int   hsync_run;
  int   vsync_run;
  logic line_stalled;
  logic full_seen;
  logic prev_hsync;
  logic prev_vsync;

  display_top #(
    .timing     (tb_timing),
    .fifo_depth (fifo_depth),
    .prefill    (prefill)
  ) display_top_i (
    .clk         (clk),
    .reset       (reset),
    .color_code  (color_code),
    .write_en    (write_en),
    .fifo_full   (fifo_full),
    .display_out (display_out)
  );

  always #4 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_rgb(input rgb_t actual, input rgb_t expected, input string what);
    if (actual !== expected) begin
      stop_on_error($sformatf("FAIL %0t: %s, got %h expected %h", $time, what, actual,
                              expected));
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      stop_on_error($sformatf("FAIL %0t: %s, got %b expected %b", $time, what, actual,
                              expected));
    end
  endtask

  task automatic check_count(input int actual, input int expected, input string what);
    if (actual != expected) begin
      stop_on_error($sformatf("FAIL %0t: %s, got %0d expected %0d", $time, what, actual,
                              expected));
    end
  endtask

  // each color bit turns its channel fully on
  function automatic rgb_t code_to_rgb(input color_code_t code);
    return {{8{code[2]}}, {8{code[1]}}, {8{code[0]}}};
  endfunction

  // called on a rising edge and returns on the edge that takes the write
  task automatic write_code(input color_code_t code);
    int wait_cycles;
    color_code <= code;
    write_en   <= 1'b1;
    wait_cycles = 0;
    @(negedge clk);
    while (fifo_full) begin
      wait_cycles++;
      if (wait_cycles > wait_limit) begin
        stop_on_error("timeout waiting for room in the pixel FIFO");
      end
      @(negedge clk);
    end
    @(posedge clk);
    expected_codes.push_back(code);
    accepted_count++;
  endtask

  task automatic hold_idle(input int cycles);
    write_en <= 1'b0;
    repeat (cycles) @(posedge clk);
  endtask

  // output monitor samples between edges
  always @(negedge clk) begin
    color_code_t shown_code;
    if (!reset) begin
      if (accepted_count < prefill) begin
        check_flag(display_out.blank, 1'b1, "blank before prefill");
        check_flag(display_out.hsync, 1'b1, "hsync before prefill");
        check_flag(display_out.vsync, 1'b1, "vsync before prefill");
        check_flag(fifo_full, 1'b0, "fifo_full before prefill");
      end
      if (fifo_full) begin
        full_seen = 1'b1;
      end
      if (!display_out.hsync || !display_out.vsync) begin
        check_flag(display_out.blank, 1'b1, "blank during sync");
      end
      if (!display_out.blank) begin
        if (expected_codes.size() == 0) begin
          stop_on_error("a pixel was shown with no written code left to show");
        end
        shown_code = expected_codes.pop_front();
        check_rgb(display_out.rgb, code_to_rgb(shown_code), "pixel color");
        line_count++;
        frame_count++;
      end else begin
        check_rgb(display_out.rgb, '0, "rgb while blank");
        if (display_out.hsync && line_count > 0 && line_count < line_pixels) begin
          line_stalled = 1'b1;
        end
      end
      check_flag(expected_codes.size() <= fifo_depth, 1'b1, "writes ahead of display");
      // sync pulse widths
      if (!display_out.hsync) begin
        hsync_run++;
      end else if (hsync_run != 0) begin
        check_count(hsync_run, hsync_width, "hsync width");
        hsync_run = 0;
      end
      if (!display_out.vsync) begin
        vsync_run++;
      end else if (vsync_run != 0) begin
        check_count(vsync_run, line_len, "vsync width");
        vsync_run = 0;
      end
      if (prev_hsync && !display_out.hsync) begin
        if (!line_stalled && line_count != 0) begin
          check_count(line_count, line_pixels, "pixels per line");
        end
        line_count   = 0;
        line_stalled = 1'b0;
      end
      if (prev_vsync && !display_out.vsync) begin
        check_count(frame_count, frame_pixels, "pixels per frame");
        frame_count = 0;
        frames_seen++;
      end
      prev_hsync = display_out.hsync;
      prev_vsync = display_out.vsync;
    end
  end

  // watchdog for the whole run
  initial begin
    repeat (run_limit) @(posedge clk);
    stop_on_error("overall timeout, the run did not finish");
  end

  initial begin
    int unsigned seed_value;
    color_code_t code;
    int          wait_cycles;
    clk             = 1'b0;
    reset           = 1'b1;
    write_en        = 1'b0;
    color_code      = '0;
    accepted_count  = 0;
    line_count      = 0;
    frame_count     = 0;
    frames_seen     = 0;
    hsync_run       = 0;
    vsync_run       = 0;
    line_stalled    = 1'b0;
    full_seen       = 1'b0;
    prev_hsync      = 1'b1;
    prev_vsync      = 1'b1;
    seed_value      = $urandom(4);

    // slow start, then a burst, then gaps long enough to underrun
    stim_table = '{
      '{3'd1, 8'd3}, '{3'd2, 8'd3}, '{3'd4, 8'd3}, '{3'd7, 8'd3},
      '{3'd0, 8'd0}, '{3'd3, 8'd0}, '{3'd5, 8'd0}, '{3'd6, 8'd0},
      '{3'd1, 8'd20}, '{3'd2, 8'd0}, '{3'd4, 8'd20}, '{3'd7, 8'd0},
      '{3'd6, 8'd20}, '{3'd5, 8'd0}, '{3'd3, 8'd1}, '{3'd0, 8'd1}
    };

    repeat (4) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < table_len; i++) begin
      hold_idle(int'(stim_table[i].idle));
      write_code(stim_table[i].code);
    end

    // full rate writes fill the FIFO
    for (int i = 0; i < random_count; i++) begin
      code = 3'($urandom);
      write_code(code);
    end
    hold_idle(1);

    wait_cycles = 0;
    while (expected_codes.size() != 0) begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles > run_limit) begin
        stop_on_error("timeout waiting for written pixels to be displayed");
      end
    end

    wait_cycles = 0;
    while (frames_seen < total_writes / frame_pixels) begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles > wait_limit) begin
        stop_on_error("timeout waiting for the last frame to finish");
      end
    end

    check_flag(full_seen, 1'b1, "fifo_full during the burst");
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/display_timing_pkg.sv
rtl/pixel_pkg.sv
rtl/pixel_fifo.sv
rtl/scan_counter.sv
rtl/scan_fsm.sv
rtl/pixel_output_stage.sv
rtl/display_top.sv
verification/display_tb.sv
